// ==== design/rv_execute_config.svh ====
`ifndef RV_EXECUTE_CONFIG_SVH
`define RV_EXECUTE_CONFIG_SVH

// Data path and address width of the core
`define XLEN 32

// Shift amount field, low bits of the second operand
`define SHAMT_W 5

// First fetch address out of reset, mirrored by the testbench model
`define RESET_PC 32'h0000_0000

`endif

// ==== design/rv_execute_pkg.sv ====
`include "rv_execute_config.svh"

package rv_execute_pkg;

  // RV32I major opcodes handled by this stage
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    CLS_ILLEGAL = 4'd0,
    CLS_OP      = 4'd1,
    CLS_OP_IMM  = 4'd2,
    CLS_LUI     = 4'd3,
    CLS_AUIPC   = 4'd4,
    CLS_LOAD    = 4'd5,
    CLS_STORE   = 4'd6,
    CLS_BRANCH  = 4'd7,
    CLS_JAL     = 4'd8,
    CLS_JALR    = 4'd9
  } op_class_e;

  typedef struct packed {
    logic [31:0]        instruction;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
  } ex_in_t;

  typedef struct packed {
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic [2:0]         funct3;
    logic               alt;        // SUB / SRA / SRAI select
    logic               use_funct;  // Clear means plain add
  } alu_req_t;

  typedef struct packed {
    op_class_e          op_class;
    logic [2:0]         funct3;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   imm;
  } br_req_t;

  typedef struct packed {
    logic               taken;
    logic [`XLEN-1:0]   target;
    logic [`XLEN-1:0]   link;       // Return address, pc + 4
  } br_res_t;

  typedef struct packed {
    logic [`XLEN-1:0]   value;
    logic               write_en;
    logic               redirect;
    logic [`XLEN-1:0]   target;
  } ex_result_t;

endpackage

// ==== design/rv_ex_decode.sv ====
`timescale 1ns/1ps
`include "rv_execute_config.svh"

module rv_ex_decode (
  input  rv_execute_pkg::ex_in_t    in_data,
  output rv_execute_pkg::alu_req_t  alu_req,
  output rv_execute_pkg::br_req_t   br_req,
  output rv_execute_pkg::op_class_e op_class
);

  import rv_execute_pkg::*;

  logic [31:0]      ins;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  assign ins    = in_data.instruction;
  assign funct3 = ins[14:12];

  // Immediate formats, all sign extended from bit 31
  assign imm_i = {{(`XLEN-12){ins[31]}}, ins[31:20]};
  assign imm_s = {{(`XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_b = {{(`XLEN-13){ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imm_u = {ins[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  always_comb begin
    case (ins[6:0])
      OPC_OP:     op_class = CLS_OP;
      OPC_OP_IMM: op_class = CLS_OP_IMM;
      OPC_LUI:    op_class = CLS_LUI;
      OPC_AUIPC:  op_class = CLS_AUIPC;
      OPC_LOAD:   op_class = CLS_LOAD;
      OPC_STORE:  op_class = CLS_STORE;
      OPC_BRANCH: op_class = CLS_BRANCH;
      OPC_JAL:    op_class = CLS_JAL;
      OPC_JALR:   op_class = CLS_JALR;
      default:    op_class = CLS_ILLEGAL;
    endcase
  end

  // ALU operands, default is rs1 + I-immediate
  always_comb begin
    alu_req.op_a      = in_data.rs1_data;
    alu_req.op_b      = imm_i;
    alu_req.funct3    = funct3;
    alu_req.alt       = 1'b0;
    alu_req.use_funct = 1'b0;
    case (op_class)
      CLS_OP: begin
        alu_req.op_b      = in_data.rs2_data;
        alu_req.use_funct = 1'b1;
        alu_req.alt       = ins[30] && (funct3 == 3'b000 || funct3 == 3'b101); // SUB, SRA
      end
      CLS_OP_IMM: begin
        alu_req.use_funct = 1'b1;
        alu_req.alt       = ins[30] && (funct3 == 3'b101); // SRAI only
      end
      CLS_LUI: begin
        alu_req.op_a = '0;
        alu_req.op_b = imm_u;
      end
      CLS_AUIPC: begin
        alu_req.op_a = in_data.pc;
        alu_req.op_b = imm_u;
      end
      CLS_STORE: alu_req.op_b = imm_s;
      default: ;                          // LOAD keeps rs1 + imm_i
    endcase
  end

  always_comb begin
    br_req.op_class = op_class;
    br_req.funct3   = funct3;
    br_req.rs1_data = in_data.rs1_data;
    br_req.rs2_data = in_data.rs2_data;
    br_req.pc       = in_data.pc;
    case (op_class)
      CLS_JAL:  br_req.imm = imm_j;
      CLS_JALR: br_req.imm = imm_i;
      default:  br_req.imm = imm_b;
    endcase
  end

endmodule

// ==== design/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_execute_config.svh"

module rv_alu (
  input  rv_execute_pkg::alu_req_t alu_req,
  output logic [`XLEN-1:0]         alu_result
);

  logic               sub;
  logic [`XLEN-1:0]   b_eff;
  logic [`XLEN-1:0]   sum;
  logic [`SHAMT_W-1:0] shamt;
  logic               lt_s;
  logic               lt_u;

  // Subtract only for OP funct3 000 with the alternate bit
  assign sub   = alu_req.use_funct && (alu_req.funct3 == 3'b000) && alu_req.alt;
  assign b_eff = sub ? ~alu_req.op_b : alu_req.op_b;
  assign sum   = alu_req.op_a + b_eff + {{(`XLEN-1){1'b0}}, sub}; // Shared adder, carry-in on SUB

  assign shamt = alu_req.op_b[`SHAMT_W-1:0];
  assign lt_s  = $signed(alu_req.op_a) < $signed(alu_req.op_b);
  assign lt_u  = alu_req.op_a < alu_req.op_b;

  always_comb begin
    if (!alu_req.use_funct) begin
      alu_result = sum;                   // Address and upper-immediate forms
    end else begin
      case (alu_req.funct3)
        3'b000: alu_result = sum;         // ADD / SUB
        3'b001: alu_result = alu_req.op_a << shamt;
        3'b010: alu_result = {{(`XLEN-1){1'b0}}, lt_s};
        3'b011: alu_result = {{(`XLEN-1){1'b0}}, lt_u};
        3'b100: alu_result = alu_req.op_a ^ alu_req.op_b;
        3'b101: begin
          if (alu_req.alt)
            alu_result = $unsigned($signed(alu_req.op_a) >>> shamt); // SRA
          else
            alu_result = alu_req.op_a >> shamt;
        end
        3'b110: alu_result = alu_req.op_a | alu_req.op_b;
        default: alu_result = alu_req.op_a & alu_req.op_b;
      endcase
    end
  end

endmodule

// ==== design/rv_branch_unit.sv ====
`timescale 1ns/1ps
`include "rv_execute_config.svh"

module rv_branch_unit (
  input  rv_execute_pkg::br_req_t br_req,
  output rv_execute_pkg::br_res_t br_res
);

  import rv_execute_pkg::*;

  logic             eq;
  logic             lt_s;
  logic             lt_u;
  logic             cond;
  logic [`XLEN-1:0] base;
  logic [`XLEN-1:0] sum;

  // Direct comparisons, immune to overflow of rs1 - rs2
  assign eq   = br_req.rs1_data == br_req.rs2_data;
  assign lt_s = $signed(br_req.rs1_data) < $signed(br_req.rs2_data);
  assign lt_u = br_req.rs1_data < br_req.rs2_data;

  always_comb begin
    case (br_req.funct3)
      3'b000:  cond = eq;       // BEQ
      3'b001:  cond = !eq;      // BNE
      3'b100:  cond = lt_s;     // BLT
      3'b101:  cond = !lt_s;    // BGE
      3'b110:  cond = lt_u;     // BLTU
      3'b111:  cond = !lt_u;    // BGEU
      default: cond = 1'b0;
    endcase
  end

  // JALR is register relative, everything else pc relative
  assign base = (br_req.op_class == CLS_JALR) ? br_req.rs1_data : br_req.pc;
  assign sum  = base + br_req.imm;

  always_comb begin
    case (br_req.op_class)
      CLS_BRANCH:        br_res.taken = cond;
      CLS_JAL, CLS_JALR: br_res.taken = 1'b1;
      default:           br_res.taken = 1'b0;
    endcase
  end

  assign br_res.target = (br_req.op_class == CLS_JALR) ? {sum[`XLEN-1:1], 1'b0} : sum;
  assign br_res.link   = br_req.pc + `XLEN'd4;

endmodule

// ==== design/rv_result_merge.sv ====
`timescale 1ns/1ps
`include "rv_execute_config.svh"

module rv_result_merge (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  input  rv_execute_pkg::op_class_e  op_class,
  input  logic [`XLEN-1:0]           alu_result,
  input  rv_execute_pkg::br_res_t    br_res,
  output logic                       out_valid,
  output rv_execute_pkg::ex_result_t out_data
);

  import rv_execute_pkg::*;

  ex_result_t nxt;

  always_comb begin
    nxt = '0;                             // ILLEGAL stays all zero
    case (op_class)
      CLS_OP, CLS_OP_IMM, CLS_LUI, CLS_AUIPC: begin
        nxt.value    = alu_result;
        nxt.write_en = 1'b1;
      end
      CLS_LOAD, CLS_STORE: nxt.value = alu_result; // Memory address only
      CLS_BRANCH: begin
        nxt.redirect = br_res.taken;
        nxt.target   = br_res.target;     // Reported even when not taken
      end
      CLS_JAL, CLS_JALR: begin
        nxt.value    = br_res.link;
        nxt.write_en = 1'b1;
        nxt.redirect = 1'b1;
        nxt.target   = br_res.target;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid         <= 1'b0;
      out_data.write_en <= 1'b0;
      out_data.redirect <= 1'b0;
    end else begin
      out_valid <= in_valid;              // One cycle pulse per instruction
      if (in_valid) begin
        out_data.write_en <= nxt.write_en;
        out_data.redirect <= nxt.redirect;
      end
    end
    if (in_valid) begin
      out_data.value  <= nxt.value;
      out_data.target <= nxt.target;
    end
  end

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_execute_config.svh"

module rv_execute (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  input  rv_execute_pkg::ex_in_t     in_data,
  output logic                       out_valid,
  output rv_execute_pkg::ex_result_t out_data
);

  import rv_execute_pkg::*;

  alu_req_t         alu_req;
  br_req_t          br_req;
  op_class_e        op_class;
  br_res_t          br_res;
  logic [`XLEN-1:0] alu_result;

  rv_ex_decode i_decode (
    .in_data  (in_data),
    .alu_req  (alu_req),
    .br_req   (br_req),
    .op_class (op_class)
  );

  // ALU and branch unit work side by side on the same instruction
  rv_alu i_alu (
    .alu_req    (alu_req),
    .alu_result (alu_result)
  );

  rv_branch_unit i_branch (
    .br_req (br_req),
    .br_res (br_res)
  );

  rv_result_merge i_merge (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .op_class   (op_class),
    .alu_result (alu_result),
    .br_res     (br_res),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

endmodule

// ==== tests/rv_execute_checker.sv ====
`timescale 1ns/1ps
`include "rv_execute_config.svh"

module rv_execute_checker (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  input  rv_execute_pkg::ex_in_t     in_data,
  input  logic                       out_valid,
  input  rv_execute_pkg::ex_result_t out_data,
  output int                         error_count,
  output int                         checked_count
);

  import rv_execute_pkg::*;

  ex_result_t expected_q[$];              // One entry per accepted instruction
  ex_result_t expected;
  ex_result_t last_seen;
  logic       have_last = 1'b0;
  logic       was_reset = 1'b0;
  logic       started   = 1'b0;

  initial begin
    error_count   = 0;
    checked_count = 0;
  end

  function automatic logic [`XLEN-1:0] shift_right_arith(logic [`XLEN-1:0] v,
                                                         logic [`SHAMT_W-1:0] n);
    logic [`XLEN-1:0] fill;
    fill = v[`XLEN-1] ? ~({`XLEN{1'b1}} >> n) : '0; // Sign bits shifted in from the top
    return (v >> n) | fill;
  endfunction

  // Expected stage output straight from the RV32I encoding rules
  function automatic ex_result_t model_result(ex_in_t d);
    logic [31:0]         ins;
    logic [2:0]          f3;
    logic [`XLEN-1:0]    a;
    logic [`XLEN-1:0]    b;
    logic [`XLEN-1:0]    imm_i;
    logic [`XLEN-1:0]    imm_s;
    logic [`XLEN-1:0]    imm_b;
    logic [`XLEN-1:0]    imm_u;
    logic [`XLEN-1:0]    imm_j;
    logic [`SHAMT_W-1:0] sh;
    logic                take;
    ex_result_t          r;
    ins   = d.instruction;
    f3    = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    a     = d.rs1_data;
    b     = (ins[6:0] == OPC_OP) ? d.rs2_data : imm_i;
    sh    = b[`SHAMT_W-1:0];
    r     = '0;
    case (ins[6:0])
      OPC_OP, OPC_OP_IMM: begin
        case (f3)
          3'b000: r.value = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
          3'b001: r.value = a << sh;
          3'b010: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b011: r.value = (a < b) ? 32'd1 : 32'd0;
          3'b100: r.value = a ^ b;
          3'b101: r.value = ins[30] ? shift_right_arith(a, sh) : a >> sh;
          3'b110: r.value = a | b;
          default: r.value = a & b;
        endcase
        r.write_en = 1'b1;
      end
      OPC_LUI: begin
        r.value    = imm_u;
        r.write_en = 1'b1;
      end
      OPC_AUIPC: begin
        r.value    = d.pc + imm_u;
        r.write_en = 1'b1;
      end
      OPC_LOAD:  r.value = d.rs1_data + imm_i;
      OPC_STORE: r.value = d.rs1_data + imm_s;
      OPC_BRANCH: begin
        case (f3)
          3'b000:  take = d.rs1_data == d.rs2_data;
          3'b001:  take = d.rs1_data != d.rs2_data;
          3'b100:  take = $signed(d.rs1_data) < $signed(d.rs2_data);
          3'b101:  take = $signed(d.rs1_data) >= $signed(d.rs2_data);
          3'b110:  take = d.rs1_data < d.rs2_data;
          3'b111:  take = d.rs1_data >= d.rs2_data;
          default: take = 1'b0;
        endcase
        r.redirect = take;
        r.target   = d.pc + imm_b;         // Target shows up even when not taken
      end
      OPC_JAL, OPC_JALR: begin
        r.value    = d.pc + 32'd4;
        r.write_en = 1'b1;
        r.redirect = 1'b1;
        if (ins[6:0] == OPC_JAL)
          r.target = d.pc + imm_j;
        else
          r.target = (d.rs1_data + imm_i) & ~32'd1;
      end
      default: ;                          // Illegal opcode gives all zero
    endcase
    return r;
  endfunction

  always @(posedge clk) begin
    started   = 1'b1;
    was_reset = reset;
    if (!reset && in_valid)
      expected_q.push_back(model_result(in_data));
  end

  // Outputs are compared half a cycle after they update
  always @(negedge clk) begin
    if (started && was_reset) begin
      if (out_valid !== 1'b0 || out_data.write_en !== 1'b0 || out_data.redirect !== 1'b0) begin
        $display("mismatch at %0d ns: reset did not clear out_valid, write_en and redirect",
                 $time);
        error_count++;
      end
    end else if (started && out_valid === 1'b1) begin
      if (expected_q.size() == 0) begin
        $display("Unexpected out_valid at %0d ns with no instruction the cycle before", $time);
        error_count++;
      end else begin
        expected = expected_q.pop_front();
        checked_count++;
        if (out_data !== expected) begin
          $display("mismatch at %0d ns: got value %h we %b redir %b target %h", $time,
                   out_data.value, out_data.write_en, out_data.redirect, out_data.target);
          $display("  expected value %h we %b redir %b target %h", expected.value,
                   expected.write_en, expected.redirect, expected.target);
          error_count++;
        end
      end
      last_seen = out_data;
      have_last = 1'b1;
    end else if (started) begin
      if (expected_q.size() != 0) begin
        $display("Missing out_valid at %0d ns one cycle after an instruction", $time);
        expected = expected_q.pop_front();
        error_count++;
      end
      if (have_last && out_data !== last_seen) begin
        $display("mismatch at %0d ns: out_data changed during an idle cycle", $time);
        error_count++;
      end
    end
  end

endmodule

// ==== tests/tb_rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_execute_config.svh"

module tb_rv_execute;

  import rv_execute_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_INSTR      = 500;
  localparam int MAX_IDLE       = 4;
  // Worst case is one busy cycle plus MAX_IDLE idle cycles per instruction
  localparam int TIMEOUT_CYCLES = NUM_INSTR * (MAX_IDLE + 1) + RESET_CYCLES + 20;

  logic             clk;
  logic             reset;
  logic             in_valid;
  ex_in_t           in_data;
  logic             out_valid;
  ex_result_t       out_data;
  int               error_count;
  int               checked_count;
  int               total_errors;
  int               sent;
  int               idle;
  logic [`XLEN-1:0] pc;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_execute i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  rv_execute_checker i_checker (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .error_count   (error_count),
    .checked_count (checked_count)
  );

  function automatic logic [`XLEN-1:0] random_operand();
    logic [`XLEN-1:0] v;
    case ($urandom_range(7))
      0:       v = '0;
      1:       v = '1;
      2:       v = 32'h8000_0000;              // Most negative
      3:       v = 32'h7fff_ffff;
      default: v = $urandom;
    endcase
    return v;
  endfunction

  function automatic logic is_rv32i_opcode(logic [6:0] opc);
    case (opc)
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_LOAD,
      OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] random_instruction();
    logic [31:0] ins;
    int          pick;
    ins  = $urandom;
    pick = $urandom_range(17);
    case (pick)
      0, 1: begin
        ins[6:0] = OPC_OP;
        if (ins[14:12] == 3'b000 || ins[14:12] == 3'b101)
          ins[31:25] = ($urandom_range(1) == 1) ? 7'h20 : 7'h00; // SUB, SRA
        else
          ins[31:25] = 7'h00;
      end
      2, 3: begin
        ins[6:0] = OPC_OP_IMM;
        if (ins[14:12] == 3'b001)
          ins[31:25] = 7'h00;
        else if (ins[14:12] == 3'b101)
          ins[31:25] = ($urandom_range(1) == 1) ? 7'h20 : 7'h00; // SRAI
      end
      4:       ins[6:0] = OPC_LUI;
      5:       ins[6:0] = OPC_AUIPC;
      6, 7:    ins[6:0] = OPC_LOAD;
      8, 9:    ins[6:0] = OPC_STORE;
      10, 11, 12: begin
        ins[6:0] = OPC_BRANCH;
        case ($urandom_range(5))
          0:       ins[14:12] = 3'b000;
          1:       ins[14:12] = 3'b001;
          2:       ins[14:12] = 3'b100;
          3:       ins[14:12] = 3'b101;
          4:       ins[14:12] = 3'b110;
          default: ins[14:12] = 3'b111;
        endcase
      end
      13:      ins[6:0] = OPC_JAL;
      14, 15:  ins[6:0] = OPC_JALR;
      default: begin
        ins[6:0] = OPC_OP;
        while (is_rv32i_opcode(ins[6:0]))
          ins[6:0] = 7'($urandom_range(127));
      end
    endcase
    return ins;
  endfunction

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    in_valid = 1'b0;
    in_data  = '0;
    sent     = 0;
    pc       = `RESET_PC;
    void'($urandom(25));
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < NUM_INSTR; i++) begin
      if ($urandom_range(3) == 0) begin   // Idle gap before about one in four
        in_valid = 1'b0;
        idle     = $urandom_range(MAX_IDLE, 1);
        repeat (idle) begin
          in_data.instruction = random_instruction(); // Junk the stage must not latch
          in_data.pc          = $urandom;
          in_data.rs1_data    = random_operand();
          in_data.rs2_data    = random_operand();
          @(negedge clk);
        end
      end
      in_data.instruction = random_instruction();
      in_data.pc          = pc;
      in_data.rs1_data    = random_operand();
      in_data.rs2_data    = ($urandom_range(7) == 0) ? in_data.rs1_data : random_operand();
      in_valid            = 1'b1;
      sent++;
      pc = ($urandom_range(15) == 0) ? ($urandom & 32'hffff_fffc) : pc + 32'd4;
      @(negedge clk);
    end
    in_valid = 1'b0;
    repeat (3) @(negedge clk);
    total_errors = error_count;
    if (checked_count != sent) begin
      $display("Only %0d of %0d instructions produced a result", checked_count, sent);
      total_errors++;
    end
    $display("Instructions sent %0d, results checked %0d, errors %0d",
             sent, checked_count, total_errors);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d clock cycles, stimulus did not finish", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== rv_execute.f ====
+incdir+design
design/rv_execute_pkg.sv
design/rv_ex_decode.sv
design/rv_alu.sv
design/rv_branch_unit.sv
design/rv_result_merge.sv
design/rv_execute.sv
tests/rv_execute_checker.sv
tests/tb_rv_execute.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f rv_execute.f \
  --top-module tb_rv_execute \
  -o tb_rv_execute

sim_output=$(./obj_dir/tb_rv_execute)
echo "$sim_output"

if grep -qx "Test OK" <<< "$sim_output"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
